// ==== design/expipe_pkg.sv ====
package expipe_pkg;

  // ------------------------------
  // Datapath widths
  // ------------------------------
  // Register and result word
  localparam int unsigned DATA_W = 32;
  // LDI immediate, zero-extended to DATA_W at execute
  localparam int unsigned IMM_W = 16;

  // Depth of the arithmetic pipeline in cycles
  // Must be at least 2 (operand stage plus one result stage)
  localparam int unsigned ALU_LAT = 3;

  // ------------------------------
  // Opcodes
  // ------------------------------
  typedef enum logic [1:0] {
    // rd = rs1 + rs2
    OP_ADD = 2'b00,
    // rd = rs1 - rs2
    OP_SUB = 2'b01,
    // rd = zero-extended immediate, no sources read
    OP_LDI = 2'b10
  } op_e;

endpackage

// ==== design/reg_status.sv ====
`timescale 1ns/1ps

module reg_status #(
  parameter  int unsigned REG_NUM   = 16,
  parameter  int unsigned ROB_DEPTH = 8,
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM),
  localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Destination claim from the issue stage
  input  logic                 issue_valid_i,
  input  logic [REG_IDX_W-1:0] issue_rd_idx_i,
  input  logic [ROB_IDX_W-1:0] issue_rob_idx_i,

  // Source lookup for the issue stage
  input  logic [REG_IDX_W-1:0] issue_rs1_idx_i,
  input  logic [REG_IDX_W-1:0] issue_rs2_idx_i,
  output logic                 issue_rs1_busy_o,
  output logic [ROB_IDX_W-1:0] issue_rs1_rob_idx_o,
  output logic                 issue_rs2_busy_o,
  output logic [ROB_IDX_W-1:0] issue_rs2_rob_idx_o,

  // Release from the commit side
  input  logic                 comm_valid_i,
  input  logic [REG_IDX_W-1:0] comm_rd_idx_i
);

  // Counter must reach ROB_DEPTH, so one bit wider than a ROB index
  localparam int unsigned CNT_W = ROB_IDX_W + 1;
  localparam logic [CNT_W-1:0] CNT_ONE = 1;

  // In-flight writer count per register
  logic [CNT_W-1:0]     cnt_q     [REG_NUM];
  // ROB entry of the newest writer
  logic [ROB_IDX_W-1:0] rob_idx_q [REG_NUM];

  // One-hot decode of the issue and commit targets
  logic [REG_NUM-1:0]   issue_hit;
  logic [REG_NUM-1:0]   comm_hit;

  always_comb begin
    issue_hit = '0;
    comm_hit  = '0;
    issue_hit[issue_rd_idx_i] = issue_valid_i;
    comm_hit[comm_rd_idx_i]   = comm_valid_i;
  end

  // ------------------------------
  // Busy counters
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < REG_NUM; r++) begin
        cnt_q[r] <= '0;
      end
    end else begin
      for (int r = 0; r < REG_NUM; r++) begin
        // Issue and commit on the same register cancel out
        if (issue_hit[r] && !comm_hit[r]) begin
          cnt_q[r] <= cnt_q[r] + CNT_ONE;
        end else if (comm_hit[r] && !issue_hit[r]) begin
          cnt_q[r] <= cnt_q[r] - CNT_ONE;
        end
      end
    end
  end

  // Newest producer always wins, also against a same-cycle commit
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      rob_idx_q[issue_rd_idx_i] <= issue_rob_idx_i;
    end
  end

  // ------------------------------
  // Lookup ports
  // ------------------------------
  // Busy while any writer is still in flight
  assign issue_rs1_busy_o    = |cnt_q[issue_rs1_idx_i];
  assign issue_rs1_rob_idx_o = rob_idx_q[issue_rs1_idx_i];
  assign issue_rs2_busy_o    = |cnt_q[issue_rs2_idx_i];
  assign issue_rs2_rob_idx_o = rob_idx_q[issue_rs2_idx_i];

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
  parameter  int unsigned REG_NUM   = 16,
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM)
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Read ports, combinational
  input  logic [REG_IDX_W-1:0]          rd1_idx_i,
  output logic [expipe_pkg::DATA_W-1:0] rd1_data_o,
  input  logic [REG_IDX_W-1:0]          rd2_idx_i,
  output logic [expipe_pkg::DATA_W-1:0] rd2_data_o,

  // Commit write port
  input  logic                          wr_valid_i,
  input  logic [REG_IDX_W-1:0]          wr_idx_i,
  input  logic [expipe_pkg::DATA_W-1:0] wr_data_i
);

  // Architectural state
  logic [expipe_pkg::DATA_W-1:0] regs_q [REG_NUM];

  // Registers come out of reset as zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < REG_NUM; r++) begin
        regs_q[r] <= '0;
      end
    end else if (wr_valid_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // No write bypass, a busy source is read from the ROB instead
  assign rd1_data_o = regs_q[rd1_idx_i];
  assign rd2_data_o = regs_q[rd2_idx_i];

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage #(
  parameter  int unsigned REG_NUM   = 16,
  parameter  int unsigned ROB_DEPTH = 8,
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM),
  localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH)
) (
  // Instruction input
  input  logic                          instr_valid_i,
  output logic                          instr_ready_o,
  input  expipe_pkg::op_e               instr_op_i,
  input  logic [REG_IDX_W-1:0]          instr_rd_i,
  input  logic [REG_IDX_W-1:0]          instr_rs1_i,
  input  logic [REG_IDX_W-1:0]          instr_rs2_i,
  input  logic [expipe_pkg::IMM_W-1:0]  instr_imm_i,

  // Register status and register file lookup
  output logic [REG_IDX_W-1:0]          rs1_idx_o,
  output logic [REG_IDX_W-1:0]          rs2_idx_o,
  input  logic                          rs1_busy_i,
  input  logic [ROB_IDX_W-1:0]          rs1_rob_idx_i,
  input  logic                          rs2_busy_i,
  input  logic [ROB_IDX_W-1:0]          rs2_rob_idx_i,
  input  logic [expipe_pkg::DATA_W-1:0] rf_rs1_data_i,
  input  logic [expipe_pkg::DATA_W-1:0] rf_rs2_data_i,

  // ROB forwarding
  output logic [ROB_IDX_W-1:0]          fwd1_idx_o,
  input  logic                          fwd1_done_i,
  input  logic [expipe_pkg::DATA_W-1:0] fwd1_data_i,
  output logic [ROB_IDX_W-1:0]          fwd2_idx_o,
  input  logic                          fwd2_done_i,
  input  logic [expipe_pkg::DATA_W-1:0] fwd2_data_i,

  // ROB allocation state
  input  logic                          rob_full_i,
  input  logic [ROB_IDX_W-1:0]          rob_tail_idx_i,

  // Launch toward reg_status, ROB and ALU
  output logic                          issue_valid_o,
  output logic [REG_IDX_W-1:0]          issue_rd_o,
  output logic [ROB_IDX_W-1:0]          issue_rob_idx_o,
  output expipe_pkg::op_e               issue_op_o,
  output logic [expipe_pkg::DATA_W-1:0] issue_a_o,
  output logic [expipe_pkg::DATA_W-1:0] issue_b_o,
  output logic [expipe_pkg::IMM_W-1:0]  issue_imm_o
);

  logic uses_src;
  logic rs1_ok;
  logic rs2_ok;
  logic can_issue;

  // ------------------------------
  // Source lookup
  // ------------------------------
  assign rs1_idx_o = instr_rs1_i;
  assign rs2_idx_o = instr_rs2_i;
  // Only the newest producer can hold a busy register's value
  assign fwd1_idx_o = rs1_rob_idx_i;
  assign fwd2_idx_o = rs2_rob_idx_i;

  // ------------------------------
  // Stall decision
  // ------------------------------
  always_comb begin
    // LDI reads no register
    uses_src  = (instr_op_i != expipe_pkg::OP_LDI);
    // Operand usable from RF, or already computed in the ROB
    rs1_ok    = !rs1_busy_i || fwd1_done_i;
    rs2_ok    = !rs2_busy_i || fwd2_done_i;
    can_issue = !rob_full_i && (!uses_src || (rs1_ok && rs2_ok));
  end

  assign instr_ready_o = can_issue;
  assign issue_valid_o = instr_valid_i && can_issue;

  // ------------------------------
  // Launch payload
  // ------------------------------
  // Tail entry becomes both the result slot and the ALU tag
  assign issue_rob_idx_o = rob_tail_idx_i;
  assign issue_rd_o      = instr_rd_i;
  assign issue_op_o      = instr_op_i;
  assign issue_imm_o     = instr_imm_i;
  // Busy source comes from the ROB, otherwise from the RF
  assign issue_a_o = rs1_busy_i ? fwd1_data_i : rf_rs1_data_i;
  assign issue_b_o = rs2_busy_i ? fwd2_data_i : rf_rs2_data_i;

endmodule

// ==== design/alu_pipe.sv ====
`timescale 1ns/1ps

module alu_pipe #(
  parameter  int unsigned ROB_DEPTH = 8,
  localparam int unsigned TAG_W     = $clog2(ROB_DEPTH),
  // Result stages after the operand stage
  localparam int unsigned RES_ST    = expipe_pkg::ALU_LAT - 1
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Launch from the issue stage
  input  logic                          in_valid_i,
  input  expipe_pkg::op_e               in_op_i,
  input  logic [expipe_pkg::DATA_W-1:0] in_a_i,
  input  logic [expipe_pkg::DATA_W-1:0] in_b_i,
  input  logic [expipe_pkg::IMM_W-1:0]  in_imm_i,
  input  logic [TAG_W-1:0]              in_tag_i,

  // Writeback into the ROB
  output logic                          wb_valid_o,
  output logic [TAG_W-1:0]              wb_tag_o,
  output logic [expipe_pkg::DATA_W-1:0] wb_data_o
);

  // Stage 1, registered operands
  logic                          s1_valid_q;
  expipe_pkg::op_e               s1_op_q;
  logic [expipe_pkg::DATA_W-1:0] s1_a_q;
  logic [expipe_pkg::DATA_W-1:0] s1_b_q;
  logic [expipe_pkg::IMM_W-1:0]  s1_imm_q;
  logic [TAG_W-1:0]              s1_tag_q;

  // Stage 2 onward, result chain
  logic                          res_valid_q [RES_ST];
  logic [TAG_W-1:0]              res_tag_q   [RES_ST];
  logic [expipe_pkg::DATA_W-1:0] res_data_q  [RES_ST];

  logic [expipe_pkg::DATA_W-1:0] alu_res;

  // ------------------------------
  // Execute
  // ------------------------------
  always_comb begin
    unique case (s1_op_q)
      expipe_pkg::OP_ADD: alu_res = s1_a_q + s1_b_q;
      expipe_pkg::OP_SUB: alu_res = s1_a_q - s1_b_q;
      expipe_pkg::OP_LDI: alu_res = {{(expipe_pkg::DATA_W - expipe_pkg::IMM_W){1'b0}}, s1_imm_q};
      default:            alu_res = '0;
    endcase
  end

  // Valid bits shift down the pipe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      for (int i = 0; i < RES_ST; i++) begin
        res_valid_q[i] <= 1'b0;
      end
    end else begin
      s1_valid_q     <= in_valid_i;
      res_valid_q[0] <= s1_valid_q;
      for (int i = 1; i < RES_ST; i++) begin
        res_valid_q[i] <= res_valid_q[i-1];
      end
    end
  end

  // Payload follows its valid bit
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      s1_op_q  <= in_op_i;
      s1_a_q   <= in_a_i;
      s1_b_q   <= in_b_i;
      s1_imm_q <= in_imm_i;
      s1_tag_q <= in_tag_i;
    end
    res_tag_q[0]  <= s1_tag_q;
    res_data_q[0] <= alu_res;
    for (int i = 1; i < RES_ST; i++) begin
      res_tag_q[i]  <= res_tag_q[i-1];
      res_data_q[i] <= res_data_q[i-1];
    end
  end

  assign wb_valid_o = res_valid_q[RES_ST-1];
  assign wb_tag_o   = res_tag_q[RES_ST-1];
  assign wb_data_o  = res_data_q[RES_ST-1];

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer #(
  parameter  int unsigned ROB_DEPTH = 8,
  parameter  int unsigned REG_NUM   = 16,
  localparam int unsigned IDX_W     = $clog2(ROB_DEPTH),
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM),
  // Extra wrap bit separates full from empty
  localparam int unsigned PTR_W     = IDX_W + 1
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Allocation at issue
  input  logic                          alloc_valid_i,
  input  logic [REG_IDX_W-1:0]          alloc_rd_i,
  output logic [IDX_W-1:0]              tail_idx_o,
  output logic                          full_o,

  // Writeback from the ALU
  input  logic                          wb_valid_i,
  input  logic [IDX_W-1:0]              wb_idx_i,
  input  logic [expipe_pkg::DATA_W-1:0] wb_data_i,

  // Operand forwarding
  input  logic [IDX_W-1:0]              fwd1_idx_i,
  output logic                          fwd1_done_o,
  output logic [expipe_pkg::DATA_W-1:0] fwd1_data_o,
  input  logic [IDX_W-1:0]              fwd2_idx_i,
  output logic                          fwd2_done_o,
  output logic [expipe_pkg::DATA_W-1:0] fwd2_data_o,

  // In-order commit
  output logic                          comm_valid_o,
  output logic [REG_IDX_W-1:0]          comm_rd_o,
  output logic [expipe_pkg::DATA_W-1:0] comm_data_o,
  output logic [IDX_W-1:0]              comm_head_idx_o
);

  localparam logic [PTR_W-1:0] PTR_ONE = 1;

  logic [PTR_W-1:0]              head_q;
  logic [PTR_W-1:0]              tail_q;
  // Low during reset and the cycle after, blocks allocation
  logic                          run_q;

  // Entry state
  logic                          valid_q [ROB_DEPTH];
  logic                          done_q  [ROB_DEPTH];
  logic [REG_IDX_W-1:0]          rd_q    [ROB_DEPTH];
  logic [expipe_pkg::DATA_W-1:0] data_q  [ROB_DEPTH];

  logic [IDX_W-1:0]              head_idx;
  logic [IDX_W-1:0]              tail_idx;
  logic                          empty;
  logic                          ptr_full;

  // ------------------------------
  // Pointer status
  // ------------------------------
  assign head_idx = head_q[IDX_W-1:0];
  assign tail_idx = tail_q[IDX_W-1:0];
  assign empty    = (head_q == tail_q);
  // Same slot, opposite lap
  assign ptr_full = (head_idx == tail_idx) && (head_q[IDX_W] != tail_q[IDX_W]);

  assign full_o     = ptr_full || !run_q;
  assign tail_idx_o = tail_idx;

  // ------------------------------
  // Forwarding and commit
  // ------------------------------
  assign fwd1_done_o = valid_q[fwd1_idx_i] && done_q[fwd1_idx_i];
  assign fwd1_data_o = data_q[fwd1_idx_i];
  assign fwd2_done_o = valid_q[fwd2_idx_i] && done_q[fwd2_idx_i];
  assign fwd2_data_o = data_q[fwd2_idx_i];

  // Head retires as soon as its result is in
  assign comm_valid_o    = !empty && done_q[head_idx];
  assign comm_rd_o       = rd_q[head_idx];
  assign comm_data_o     = data_q[head_idx];
  assign comm_head_idx_o = head_idx;

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q <= '0;
      tail_q <= '0;
      run_q  <= 1'b0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        valid_q[i] <= 1'b0;
        done_q[i]  <= 1'b0;
      end
    end else begin
      run_q <= 1'b1;
      // Writeback always hits an in-flight entry
      if (wb_valid_i) begin
        done_q[wb_idx_i] <= 1'b1;
      end
      if (comm_valid_o) begin
        valid_q[head_idx] <= 1'b0;
        head_q            <= head_q + PTR_ONE;
      end
      // Never the head slot here, since allocation needs a free entry
      if (alloc_valid_i) begin
        valid_q[tail_idx] <= 1'b1;
        done_q[tail_idx]  <= 1'b0;
        tail_q            <= tail_q + PTR_ONE;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (alloc_valid_i) begin
      rd_q[tail_idx] <= alloc_rd_i;
    end
    if (wb_valid_i) begin
      data_q[wb_idx_i] <= wb_data_i;
    end
  end

endmodule

// ==== design/expipe_top.sv ====
`timescale 1ns/1ps

module expipe_top #(
  parameter  int unsigned REG_NUM   = 16,
  parameter  int unsigned ROB_DEPTH = 8,
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM),
  localparam int unsigned ROB_IDX_W = $clog2(ROB_DEPTH)
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Instruction input, valid/ready
  input  logic                          instr_valid_i,
  output logic                          instr_ready_o,
  input  expipe_pkg::op_e               instr_op_i,
  input  logic [REG_IDX_W-1:0]          instr_rd_i,
  input  logic [REG_IDX_W-1:0]          instr_rs1_i,
  input  logic [REG_IDX_W-1:0]          instr_rs2_i,
  input  logic [expipe_pkg::IMM_W-1:0]  instr_imm_i,

  // Commit output, valid only
  output logic                          commit_valid_o,
  output logic [REG_IDX_W-1:0]          commit_rd_o,
  output logic [expipe_pkg::DATA_W-1:0] commit_data_o
);

  // ------------------------------
  // Interconnect
  // ------------------------------
  // Source lookup
  logic [REG_IDX_W-1:0]          rs1_idx;
  logic [REG_IDX_W-1:0]          rs2_idx;
  logic                          rs1_busy;
  logic                          rs2_busy;
  logic [ROB_IDX_W-1:0]          rs1_rob_idx;
  logic [ROB_IDX_W-1:0]          rs2_rob_idx;
  logic [expipe_pkg::DATA_W-1:0] rf_rs1_data;
  logic [expipe_pkg::DATA_W-1:0] rf_rs2_data;

  // ROB forwarding
  logic [ROB_IDX_W-1:0]          fwd1_idx;
  logic                          fwd1_done;
  logic [expipe_pkg::DATA_W-1:0] fwd1_data;
  logic [ROB_IDX_W-1:0]          fwd2_idx;
  logic                          fwd2_done;
  logic [expipe_pkg::DATA_W-1:0] fwd2_data;
  logic                          rob_full;
  logic [ROB_IDX_W-1:0]          rob_tail_idx;

  // Launch
  logic                          issue_valid;
  logic [REG_IDX_W-1:0]          issue_rd;
  logic [ROB_IDX_W-1:0]          issue_rob_idx;
  expipe_pkg::op_e               issue_op;
  logic [expipe_pkg::DATA_W-1:0] issue_a;
  logic [expipe_pkg::DATA_W-1:0] issue_b;
  logic [expipe_pkg::IMM_W-1:0]  issue_imm;

  // Writeback
  logic                          wb_valid;
  logic [ROB_IDX_W-1:0]          wb_tag;
  logic [expipe_pkg::DATA_W-1:0] wb_data;

  issue_stage #(
    .REG_NUM   (REG_NUM),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_issue (
    .instr_valid_i   (instr_valid_i),
    .instr_ready_o   (instr_ready_o),
    .instr_op_i      (instr_op_i),
    .instr_rd_i      (instr_rd_i),
    .instr_rs1_i     (instr_rs1_i),
    .instr_rs2_i     (instr_rs2_i),
    .instr_imm_i     (instr_imm_i),
    .rs1_idx_o       (rs1_idx),
    .rs2_idx_o       (rs2_idx),
    .rs1_busy_i      (rs1_busy),
    .rs1_rob_idx_i   (rs1_rob_idx),
    .rs2_busy_i      (rs2_busy),
    .rs2_rob_idx_i   (rs2_rob_idx),
    .rf_rs1_data_i   (rf_rs1_data),
    .rf_rs2_data_i   (rf_rs2_data),
    .fwd1_idx_o      (fwd1_idx),
    .fwd1_done_i     (fwd1_done),
    .fwd1_data_i     (fwd1_data),
    .fwd2_idx_o      (fwd2_idx),
    .fwd2_done_i     (fwd2_done),
    .fwd2_data_i     (fwd2_data),
    .rob_full_i      (rob_full),
    .rob_tail_idx_i  (rob_tail_idx),
    .issue_valid_o   (issue_valid),
    .issue_rd_o      (issue_rd),
    .issue_rob_idx_o (issue_rob_idx),
    .issue_op_o      (issue_op),
    .issue_a_o       (issue_a),
    .issue_b_o       (issue_b),
    .issue_imm_o     (issue_imm)
  );

  reg_status #(
    .REG_NUM   (REG_NUM),
    .ROB_DEPTH (ROB_DEPTH)
  ) u_status (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .issue_valid_i       (issue_valid),
    .issue_rd_idx_i      (issue_rd),
    .issue_rob_idx_i     (issue_rob_idx),
    .issue_rs1_idx_i     (rs1_idx),
    .issue_rs2_idx_i     (rs2_idx),
    .issue_rs1_busy_o    (rs1_busy),
    .issue_rs1_rob_idx_o (rs1_rob_idx),
    .issue_rs2_busy_o    (rs2_busy),
    .issue_rs2_rob_idx_o (rs2_rob_idx),
    .comm_valid_i        (commit_valid_o),
    .comm_rd_idx_i       (commit_rd_o)
  );

  reg_file #(
    .REG_NUM (REG_NUM)
  ) u_rf (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd1_idx_i  (rs1_idx),
    .rd1_data_o (rf_rs1_data),
    .rd2_idx_i  (rs2_idx),
    .rd2_data_o (rf_rs2_data),
    .wr_valid_i (commit_valid_o),
    .wr_idx_i   (commit_rd_o),
    .wr_data_i  (commit_data_o)
  );

  alu_pipe #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_alu (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (issue_valid),
    .in_op_i    (issue_op),
    .in_a_i     (issue_a),
    .in_b_i     (issue_b),
    .in_imm_i   (issue_imm),
    .in_tag_i   (issue_rob_idx),
    .wb_valid_o (wb_valid),
    .wb_tag_o   (wb_tag),
    .wb_data_o  (wb_data)
  );

  // Commit drives the RF, the status table and the top outputs
  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH),
    .REG_NUM   (REG_NUM)
  ) u_rob (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .alloc_valid_i   (issue_valid),
    .alloc_rd_i      (issue_rd),
    .tail_idx_o      (rob_tail_idx),
    .full_o          (rob_full),
    .wb_valid_i      (wb_valid),
    .wb_idx_i        (wb_tag),
    .wb_data_i       (wb_data),
    .fwd1_idx_i      (fwd1_idx),
    .fwd1_done_o     (fwd1_done),
    .fwd1_data_o     (fwd1_data),
    .fwd2_idx_i      (fwd2_idx),
    .fwd2_done_o     (fwd2_done),
    .fwd2_data_o     (fwd2_data),
    .comm_valid_o    (commit_valid_o),
    .comm_rd_o       (commit_rd_o),
    .comm_data_o     (commit_data_o),
    .comm_head_idx_o ()
  );

endmodule

// ==== tests/expipe_asserts.sv ====
`timescale 1ns/1ps

module expipe_asserts #(
  parameter  int unsigned REG_NUM   = 16,
  parameter  int unsigned ROB_DEPTH = 8,
  localparam int unsigned REG_IDX_W = $clog2(REG_NUM)
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          instr_valid_i,
  input  logic                          instr_ready_o,
  input  expipe_pkg::op_e               instr_op_i,
  input  logic [REG_IDX_W-1:0]          instr_rd_i,
  input  logic [REG_IDX_W-1:0]          instr_rs1_i,
  input  logic [REG_IDX_W-1:0]          instr_rs2_i,
  input  logic [expipe_pkg::IMM_W-1:0]  instr_imm_i,
  input  logic                          commit_valid_o,
  input  logic [REG_IDX_W-1:0]          commit_rd_o,
  input  logic [expipe_pkg::DATA_W-1:0] commit_data_o
);

  // Shadow queue slots, well above the ROB depth
  localparam int unsigned QD       = 32;
  // Oldest instruction must be gone within this many cycles
  localparam int unsigned LIVE_MAX = ROB_DEPTH * expipe_pkg::ALU_LAT + 8;
  // Valid rises ALU_LAT edges after acceptance, the commit edge is one later
  localparam int unsigned MIN_LAT  = expipe_pkg::ALU_LAT + 1;

  // Failure count, watched from the testbench
  int unsigned err_cnt = 0;

  int unsigned cyc;
  int unsigned acc_cnt;
  int unsigned com_cnt;
  int unsigned in_flight;
  int unsigned head;
  int unsigned tail;

  // ------------------------------
  // Program-order shadow model
  // ------------------------------
  expipe_pkg::op_e               q_op    [QD];
  logic [REG_IDX_W-1:0]          q_rd    [QD];
  logic [REG_IDX_W-1:0]          q_rs1   [QD];
  logic [REG_IDX_W-1:0]          q_rs2   [QD];
  logic [expipe_pkg::IMM_W-1:0]  q_imm   [QD];
  int unsigned                   q_cyc   [QD];
  // Nothing older was in flight at acceptance
  logic                          q_alone [QD];
  logic [expipe_pkg::DATA_W-1:0] shadow  [REG_NUM];

  logic                          accept;
  logic                          commit;
  logic [REG_IDX_W-1:0]          exp_rd;
  logic [expipe_pkg::DATA_W-1:0] exp_data;

  assign accept    = instr_valid_i && instr_ready_o;
  assign in_flight = acc_cnt - com_cnt;
  assign commit    = commit_valid_o && (in_flight != 0);
  assign head      = com_cnt % QD;
  assign tail      = acc_cnt % QD;

  // Expected result from the architectural state before the oldest instruction
  always_comb begin
    exp_rd = q_rd[head];
    case (q_op[head])
      expipe_pkg::OP_ADD: exp_data = shadow[q_rs1[head]] + shadow[q_rs2[head]];
      expipe_pkg::OP_SUB: exp_data = shadow[q_rs1[head]] - shadow[q_rs2[head]];
      default: exp_data = {{(expipe_pkg::DATA_W - expipe_pkg::IMM_W){1'b0}}, q_imm[head]};
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cyc     <= 0;
      acc_cnt <= 0;
      com_cnt <= 0;
      for (int r = 0; r < REG_NUM; r++) begin
        shadow[r] <= '0;
      end
    end else begin
      cyc <= cyc + 1;
      if (accept) begin
        acc_cnt <= acc_cnt + 1;
      end
      // Shadow registers follow the model, never the DUT data
      if (commit) begin
        shadow[exp_rd] <= exp_data;
        com_cnt        <= com_cnt + 1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      q_op[tail]    <= instr_op_i;
      q_rd[tail]    <= instr_rd_i;
      q_rs1[tail]   <= instr_rs1_i;
      q_rs2[tail]   <= instr_rs2_i;
      q_imm[tail]   <= instr_imm_i;
      q_cyc[tail]   <= cyc;
      q_alone[tail] <= (in_flight == 0);
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_commit_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      commit |-> commit_rd_o == exp_rd)
    else begin
      $error("[ERROR] commit_rd_o 0x%0h expected 0x%0h",
             $sampled(commit_rd_o), $sampled(exp_rd));
      err_cnt = err_cnt + 1;
    end

  a_commit_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      commit |-> commit_data_o == exp_data)
    else begin
      $error("[ERROR] commit_data_o 0x%0h expected 0x%0h",
             $sampled(commit_data_o), $sampled(exp_data));
      err_cnt = err_cnt + 1;
    end

  // Quiet during reset and on the first edge after release
  a_reset_quiet: assert property (@(posedge clk_i)
      (!rst_n_i || $rose(rst_n_i)) |-> !instr_ready_o && !commit_valid_o)
    else begin
      $error("[ERROR] instr_ready_o 0x%0h commit_valid_o 0x%0h expected 0x0 around reset",
             $sampled(instr_ready_o), $sampled(commit_valid_o));
      err_cnt = err_cnt + 1;
    end

  a_full_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (in_flight >= ROB_DEPTH) |-> !instr_ready_o)
    else begin
      $error("[ERROR] instr_ready_o 0x%0h expected 0x0 with 0x%0h in flight",
             $sampled(instr_ready_o), $sampled(in_flight));
      err_cnt = err_cnt + 1;
    end

  a_liveness: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (in_flight != 0) |-> (cyc - q_cyc[head]) <= LIVE_MAX)
    else begin
      $error("[ERROR] oldest instruction did not commit within %0d cycles", LIVE_MAX);
      err_cnt = err_cnt + 1;
    end

  a_min_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (commit && q_alone[head]) |-> (cyc - q_cyc[head]) == MIN_LAT)
    else begin
      $error("[ERROR] commit latency 0x%0h expected 0x%0h",
             $sampled(cyc - q_cyc[head]), MIN_LAT);
      err_cnt = err_cnt + 1;
    end

  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      commit_valid_o |-> in_flight != 0)
    else begin
      $error("[ERROR] commit_valid_o 0x1 with no instruction in flight");
      err_cnt = err_cnt + 1;
    end

endmodule

bind expipe_top expipe_asserts #(
  .REG_NUM   (REG_NUM),
  .ROB_DEPTH (ROB_DEPTH)
) u_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .instr_valid_i  (instr_valid_i),
  .instr_ready_o  (instr_ready_o),
  .instr_op_i     (instr_op_i),
  .instr_rd_i     (instr_rd_i),
  .instr_rs1_i    (instr_rs1_i),
  .instr_rs2_i    (instr_rs2_i),
  .instr_imm_i    (instr_imm_i),
  .commit_valid_o (commit_valid_o),
  .commit_rd_o    (commit_rd_o),
  .commit_data_o  (commit_data_o)
);

// ==== tests/expipe_tb.sv ====
`timescale 1ns/1ps

module expipe_tb;

  localparam int unsigned REG_NUM     = 16;
  // Four entries, so back-to-back issue fills the ROB
  localparam int unsigned ROB_DEPTH   = 4;
  localparam int unsigned REG_IDX_W   = $clog2(REG_NUM);
  localparam int unsigned N_RANDOM    = 300;
  // Cycle limits for each wait loop
  localparam int unsigned READY_LIMIT = 200;
  localparam int unsigned DRAIN_LIMIT = 200;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          instr_valid_i;
  logic                          instr_ready_o;
  expipe_pkg::op_e               instr_op_i;
  logic [REG_IDX_W-1:0]          instr_rd_i;
  logic [REG_IDX_W-1:0]          instr_rs1_i;
  logic [REG_IDX_W-1:0]          instr_rs2_i;
  logic [expipe_pkg::IMM_W-1:0]  instr_imm_i;
  logic                          commit_valid_o;
  logic [REG_IDX_W-1:0]          commit_rd_o;
  logic [expipe_pkg::DATA_W-1:0] commit_data_o;

  int unsigned n_accepted  = 0;
  int unsigned n_committed = 0;

  expipe_top #(
    .REG_NUM   (REG_NUM),
    .ROB_DEPTH (ROB_DEPTH)
  ) expipe_top_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_op_i     (instr_op_i),
    .instr_rd_i     (instr_rd_i),
    .instr_rs1_i    (instr_rs1_i),
    .instr_rs2_i    (instr_rs2_i),
    .instr_imm_i    (instr_imm_i),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  // Commit valid is settled at the falling edge, one count per commit cycle
  always @(negedge clk_i) begin
    if (rst_n_i && commit_valid_o) begin
      n_committed = n_committed + 1;
    end
  end

  // Any failed assertion in the checker ends the run
  always @(negedge clk_i) begin
    if (expipe_top_i.u_asserts.err_cnt != 0) begin
      abort_run("an assertion in the bound checker failed");
    end
  end

  // Three picks in four hit r0..r3 to build dependency chains
  function automatic logic [REG_IDX_W-1:0] pick_reg();
    if ($urandom_range(0, 3) != 0) begin
      return REG_IDX_W'($urandom_range(0, 3));
    end else begin
      return REG_IDX_W'($urandom_range(0, REG_NUM - 1));
    end
  endfunction

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic send_instr(input expipe_pkg::op_e op, input logic [REG_IDX_W-1:0] rd,
                            input logic [REG_IDX_W-1:0] rs1, input logic [REG_IDX_W-1:0] rs2,
                            input logic [expipe_pkg::IMM_W-1:0] imm);
    int unsigned waited;
    waited        = 0;
    instr_valid_i = 1'b1;
    instr_op_i    = op;
    instr_rd_i    = rd;
    instr_rs1_i   = rs1;
    instr_rs2_i   = rs2;
    instr_imm_i   = imm;
    // Ready looked at a quarter period in, well clear of both edges
    #5;
    while (!instr_ready_o) begin
      if (waited == READY_LIMIT) begin
        abort_run("instr_ready_o stayed low too long while an instruction was offered");
      end else begin
        waited = waited + 1;
        @(negedge clk_i);
        #5;
      end
    end
    @(negedge clk_i);
    n_accepted = n_accepted + 1;
  endtask

  task automatic idle_cycles(input int unsigned n);
    instr_valid_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    int unsigned waited;
    void'($urandom(71));
    clk_i         = 1'b0;
    rst_n_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_op_i    = expipe_pkg::OP_ADD;
    instr_rd_i    = '0;
    instr_rs1_i   = '0;
    instr_rs2_i   = '0;
    instr_imm_i   = '0;
    #1;
    rst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Known value in every register
    for (int r = 0; r < REG_NUM; r++) begin
      send_instr(expipe_pkg::OP_LDI, REG_IDX_W'(r), '0, '0, expipe_pkg::IMM_W'($urandom()));
    end
    idle_cycles(8);

    for (int i = 0; i < N_RANDOM; i++) begin
      send_instr(expipe_pkg::op_e'($urandom_range(0, 2)), pick_reg(), pick_reg(), pick_reg(),
                 expipe_pkg::IMM_W'($urandom()));
      // Occasional gaps, the long ones drain the pipe completely
      if ($urandom_range(0, 7) == 0) begin
        idle_cycles($urandom_range(1, 12));
      end
    end
    idle_cycles(1);

    // Drain
    waited = 0;
    while (n_committed < n_accepted) begin
      if (waited == DRAIN_LIMIT) begin
        abort_run("pipeline did not drain, some instructions never committed");
      end else begin
        waited = waited + 1;
        @(negedge clk_i);
      end
    end
    repeat (2) @(negedge clk_i);

    if (expipe_top_i.u_asserts.err_cnt == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("assertion failures were recorded");
    end
  end

endmodule

// ==== sources.f ====
design/expipe_pkg.sv
design/reg_status.sv
design/reg_file.sv
design/issue_stage.sv
design/alu_pipe.sv
design/reorder_buffer.sv
design/expipe_top.sv
tests/expipe_asserts.sv
tests/expipe_tb.sv
